// File: rtl/id_pkg.sv
// RV32I base opcodes only; SYSTEM and MISC-MEM are not decoded and count as illegal
package id_pkg;

  //////////////////////////////////////////////////
  // Widths and field positions
  //////////////////////////////////////////////////

  // Data and address width
  localparam int XLEN       = 32;
  // Register index width
  localparam int REG_ADDR_W = 5;

  // Register fields in the instruction word
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int RD_LSB  = 7;

  // Function fields
  localparam int F3_LSB  = 12;
  localparam int F7_LSB  = 25;

  //////////////////////////////////////////////////
  // Major opcodes
  //////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;

  //////////////////////////////////////////////////
  // Select and operator encodings
  //////////////////////////////////////////////////

  // ALU operation, arithmetic first, then the branch compares
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR,  ALU_AND,
    ALU_EQ,  ALU_NE,  ALU_LT,  ALU_GE,  ALU_LTU, ALU_GEU
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REG,
    OP_A_PC,
    OP_A_ZERO
  } op_a_sel_e;

  // Operand B source
  typedef enum logic {
    OP_B_REG,
    OP_B_IMM
  } op_b_sel_e;

  // Immediate on operand B; PCINCR is the link offset of jumps
  typedef enum logic [1:0] {
    IMMB_I,
    IMMB_S,
    IMMB_U,
    IMMB_PCINCR
  } imm_b_sel_e;

  // Operand C source
  typedef enum logic [1:0] {
    OP_C_REGB,
    OP_C_BCH,
    OP_C_ZERO
  } op_c_sel_e;

  // Forwarding source, driven by the external controller
  typedef enum logic [1:0] {
    SEL_REGFILE,
    SEL_FW_EX,
    SEL_FW_WB
  } fw_sel_e;

  // Control transfer kind
  typedef enum logic [1:0] {
    XFER_NONE,
    XFER_JAL,
    XFER_JALR,
    XFER_COND
  } ctrl_xfer_e;

  // LSU access size
  typedef enum logic [1:0] {
    LSU_BYTE,
    LSU_HALF,
    LSU_WORD
  } lsu_type_e;

endpackage

// File: rtl/imm_gen.sv
// Pure combinational; B and J immediates always have bit 0 cleared
`timescale 1ns/10ps

module imm_gen import id_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  output logic [XLEN-1:0] imm_i_o,
  output logic [XLEN-1:0] imm_s_o,
  output logic [XLEN-1:0] imm_b_o,
  output logic [XLEN-1:0] imm_u_o,
  output logic [XLEN-1:0] imm_j_o
);

  // Sign bit shared by every format
  logic sign;

  assign sign = instr_i[31];

  // I type, loads, OP-IMM and JALR
  assign imm_i_o = {{20{sign}}, instr_i[31:20]};

  // S type, split around rd position
  assign imm_s_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};

  // B type, halfword offset
  assign imm_b_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

  // U type, upper 20 bits
  assign imm_u_o = {instr_i[31:12], 12'b0};

  // J type, scrambled 20 bit offset
  assign imm_j_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

endmodule

// File: rtl/instr_decoder.sv
// RV32I base set only; any other opcode or funct pattern is flagged illegal with no side effects
`timescale 1ns/10ps

module instr_decoder import id_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  output logic            alu_en_o,
  output alu_op_e         alu_op_o,
  output op_a_sel_e       op_a_sel_o,
  output op_b_sel_e       op_b_sel_o,
  output imm_b_sel_e      imm_b_sel_o,
  output op_c_sel_e       op_c_sel_o,
  output logic [1:0]      rf_re_o,
  output logic            rf_we_o,
  output logic            lsu_en_o,
  output logic            lsu_we_o,
  output lsu_type_e       lsu_type_o,
  output logic            lsu_sign_ext_o,
  output ctrl_xfer_e      ctrl_xfer_o,
  output logic            illegal_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       rd_zero;

  assign opcode  = instr_i[6:0];
  assign funct3  = instr_i[F3_LSB +: 3];
  assign funct7  = instr_i[F7_LSB +: 7];
  assign rd_zero = (instr_i[RD_LSB +: REG_ADDR_W] == '0);

  always_comb begin
    // Defaults describe a bubble
    alu_en_o       = 1'b0;
    alu_op_o       = ALU_ADD;
    op_a_sel_o     = OP_A_REG;
    op_b_sel_o     = OP_B_REG;
    imm_b_sel_o    = IMMB_I;
    op_c_sel_o     = OP_C_ZERO;
    rf_re_o        = 2'b00;
    rf_we_o        = 1'b0;
    lsu_en_o       = 1'b0;
    lsu_we_o       = 1'b0;
    lsu_type_o     = LSU_WORD;
    lsu_sign_ext_o = 1'b0;
    ctrl_xfer_o    = XFER_NONE;
    illegal_o      = 1'b0;

    unique case (opcode)
      //////////////////////////////////////////////////
      // Register and immediate arithmetic
      //////////////////////////////////////////////////
      OPC_OP_IMM, OPC_OP: begin
        alu_en_o   = 1'b1;
        rf_we_o    = 1'b1;
        rf_re_o[0] = 1'b1;
        if (opcode == OPC_OP_IMM) begin
          op_b_sel_o = OP_B_IMM;
        end else begin
          rf_re_o[1] = 1'b1;
        end
        case (funct3)
          3'b000: alu_op_o = ALU_ADD;
          3'b001: alu_op_o = ALU_SLL;
          3'b010: alu_op_o = ALU_SLT;
          3'b011: alu_op_o = ALU_SLTU;
          3'b100: alu_op_o = ALU_XOR;
          3'b101: alu_op_o = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110: alu_op_o = ALU_OR;
          default: alu_op_o = ALU_AND;
        endcase
        // funct7 bit 5 picks SUB on OP only, SRA on both
        if (opcode == OPC_OP && funct3 == 3'b000 && funct7[5]) begin
          alu_op_o = ALU_SUB;
        end
        // Legal funct7 patterns; OP-IMM ignores it except on shifts
        if (opcode == OPC_OP || funct3[1:0] == 2'b01) begin
          if ((funct7 & 7'b1011111) != 7'b0) begin
            illegal_o = 1'b1;
          end
          if (funct7[5] && !(funct3 == 3'b101 ||
              (opcode == OPC_OP && funct3 == 3'b000))) begin
            illegal_o = 1'b1;
          end
        end
      end
      // Zero plus upper immediate
      OPC_LUI: begin
        alu_en_o    = 1'b1;
        rf_we_o     = 1'b1;
        op_a_sel_o  = OP_A_ZERO;
        op_b_sel_o  = OP_B_IMM;
        imm_b_sel_o = IMMB_U;
      end
      // PC plus upper immediate
      OPC_AUIPC: begin
        alu_en_o    = 1'b1;
        rf_we_o     = 1'b1;
        op_a_sel_o  = OP_A_PC;
        op_b_sel_o  = OP_B_IMM;
        imm_b_sel_o = IMMB_U;
      end
      //////////////////////////////////////////////////
      // Jumps and branches
      //////////////////////////////////////////////////
      OPC_JAL, OPC_JALR: begin
        // Link value is PC + 4
        alu_en_o    = 1'b1;
        rf_we_o     = 1'b1;
        op_a_sel_o  = OP_A_PC;
        op_b_sel_o  = OP_B_IMM;
        imm_b_sel_o = IMMB_PCINCR;
        ctrl_xfer_o = XFER_JAL;
        if (opcode == OPC_JALR) begin
          ctrl_xfer_o = XFER_JALR;
          rf_re_o[0]  = 1'b1;
          illegal_o   = (funct3 != 3'b000);
        end
      end
      OPC_BRANCH: begin
        alu_en_o    = 1'b1;
        rf_re_o     = 2'b11;
        op_c_sel_o  = OP_C_BCH;
        ctrl_xfer_o = XFER_COND;
        case (funct3)
          3'b000: alu_op_o = ALU_EQ;
          3'b001: alu_op_o = ALU_NE;
          3'b100: alu_op_o = ALU_LT;
          3'b101: alu_op_o = ALU_GE;
          3'b110: alu_op_o = ALU_LTU;
          3'b111: alu_op_o = ALU_GEU;
          default: illegal_o = 1'b1;
        endcase
      end
      //////////////////////////////////////////////////
      // Loads and stores, address is rs1 + offset
      //////////////////////////////////////////////////
      OPC_LOAD: begin
        lsu_en_o       = 1'b1;
        rf_we_o        = 1'b1;
        rf_re_o[0]     = 1'b1;
        op_b_sel_o     = OP_B_IMM;
        lsu_type_o     = lsu_type_e'(funct3[1:0]);
        lsu_sign_ext_o = !funct3[2];
        // No LWU or 64 bit loads in RV32I
        illegal_o      = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      OPC_STORE: begin
        lsu_en_o    = 1'b1;
        lsu_we_o    = 1'b1;
        rf_re_o     = 2'b11;
        op_b_sel_o  = OP_B_IMM;
        imm_b_sel_o = IMMB_S;
        op_c_sel_o  = OP_C_REGB;
        lsu_type_o  = lsu_type_e'(funct3[1:0]);
        illegal_o   = funct3[2] || (funct3[1:0] == 2'b11);
      end
      default: illegal_o = 1'b1;
    endcase

    // Writes to x0 are dropped here
    if (rd_zero) begin
      rf_we_o = 1'b0;
    end

    // Illegal instruction has no side effects downstream
    if (illegal_o) begin
      alu_en_o    = 1'b0;
      rf_we_o     = 1'b0;
      lsu_en_o    = 1'b0;
      lsu_we_o    = 1'b0;
      ctrl_xfer_o = XFER_NONE;
    end
  end

endmodule

// File: rtl/operand_sel.sv
// Pure combinational; forwarding selects come from an external hazard controller
`timescale 1ns/10ps

module operand_sel import id_pkg::*; (
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rf_rdata_a_i,
  input  logic [XLEN-1:0] rf_rdata_b_i,
  input  logic [XLEN-1:0] rf_wdata_ex_i,
  input  logic [XLEN-1:0] rf_wdata_wb_i,
  input  fw_sel_e         fw_a_sel_i,
  input  fw_sel_e         fw_b_sel_i,
  input  op_a_sel_e       op_a_sel_i,
  input  op_b_sel_e       op_b_sel_i,
  input  imm_b_sel_e      imm_b_sel_i,
  input  op_c_sel_e       op_c_sel_i,
  input  ctrl_xfer_e      ctrl_xfer_i,
  input  logic [XLEN-1:0] imm_i_i,
  input  logic [XLEN-1:0] imm_s_i,
  input  logic [XLEN-1:0] imm_b_i,
  input  logic [XLEN-1:0] imm_u_i,
  input  logic [XLEN-1:0] imm_j_i,
  output logic [XLEN-1:0] operand_a_o,
  output logic [XLEN-1:0] operand_b_o,
  output logic [XLEN-1:0] operand_c_o,
  output logic [XLEN-1:0] jmp_target_o
);

  logic [XLEN-1:0] fw_a;
  logic [XLEN-1:0] fw_b;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] bch_target;
  logic [XLEN-1:0] jalr_target;

  //////////////////////////////////////////////////
  // Forwarding
  //////////////////////////////////////////////////

  always_comb begin
    case (fw_a_sel_i)
      SEL_FW_EX: fw_a = rf_wdata_ex_i;
      SEL_FW_WB: fw_a = rf_wdata_wb_i;
      default:   fw_a = rf_rdata_a_i;
    endcase
  end

  always_comb begin
    case (fw_b_sel_i)
      SEL_FW_EX: fw_b = rf_wdata_ex_i;
      SEL_FW_WB: fw_b = rf_wdata_wb_i;
      default:   fw_b = rf_rdata_b_i;
    endcase
  end

  //////////////////////////////////////////////////
  // Operand muxes
  //////////////////////////////////////////////////

  always_comb begin
    case (op_a_sel_i)
      OP_A_PC:   operand_a_o = pc_i;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = fw_a;
    endcase
  end

  // Immediate for B; no compressed support so link offset is fixed at 4
  always_comb begin
    case (imm_b_sel_i)
      IMMB_S:      imm_b = imm_s_i;
      IMMB_U:      imm_b = imm_u_i;
      IMMB_PCINCR: imm_b = XLEN'(4);
      default:     imm_b = imm_i_i;
    endcase
  end

  assign operand_b_o = (op_b_sel_i == OP_B_IMM) ? imm_b : fw_b;

  // Operand C carries store data or the branch target
  always_comb begin
    case (op_c_sel_i)
      OP_C_REGB: operand_c_o = fw_b;
      OP_C_BCH:  operand_c_o = bch_target;
      default:   operand_c_o = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////

  assign bch_target  = pc_i + imm_b_i;

  // JALR shares the operand A forwarding path
  assign jalr_target = (fw_a + imm_i_i) & ~XLEN'(1);

  always_comb begin
    case (ctrl_xfer_i)
      XFER_JAL:  jmp_target_o = pc_i + imm_j_i;
      XFER_JALR: jmp_target_o = jalr_target;
      default:   jmp_target_o = bch_target;
    endcase
  end

endmodule

// File: rtl/id_ex_reg.sv
// Holds one item for EX; payload fields load only when their enable is set, else keep old value
`timescale 1ns/10ps

module id_ex_reg import id_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid_i,
  input  logic                  kill_id_i,
  input  logic                  halt_id_i,
  input  logic                  ex_ready_i,
  input  logic                  alu_en_i,
  input  alu_op_e               alu_op_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       operand_b_i,
  input  logic [XLEN-1:0]       operand_c_i,
  input  logic                  rf_we_i,
  input  logic [REG_ADDR_W-1:0] rd_i,
  input  logic                  lsu_en_i,
  input  logic                  lsu_we_i,
  input  lsu_type_e             lsu_type_i,
  input  logic                  lsu_sign_ext_i,
  input  ctrl_xfer_e            ctrl_xfer_i,
  input  logic                  illegal_i,
  input  logic [XLEN-1:0]       pc_i,
  output logic                  id_valid_o,
  output logic                  id_ready_o,
  output logic                  ex_valid_o,
  output alu_op_e               ex_alu_operator_o,
  output logic [XLEN-1:0]       ex_operand_a_o,
  output logic [XLEN-1:0]       ex_operand_b_o,
  output logic [XLEN-1:0]       ex_operand_c_o,
  output logic                  ex_rf_we_o,
  output logic [REG_ADDR_W-1:0] ex_rf_waddr_o,
  output logic                  ex_lsu_en_o,
  output logic                  ex_lsu_we_o,
  output lsu_type_e             ex_lsu_type_o,
  output logic                  ex_lsu_sign_ext_o,
  output logic                  ex_branch_o,
  output logic                  ex_illegal_o,
  output logic [XLEN-1:0]       ex_pc_o
);

  logic xfer;

  // Stage handshake; kill drains ID even when EX stalls
  assign id_valid_o = instr_valid_i && !kill_id_i && !halt_id_i;
  assign id_ready_o = kill_id_i || (ex_ready_i && !halt_id_i);
  assign xfer       = id_valid_o && ex_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_o        <= 1'b0;
      ex_alu_operator_o <= ALU_ADD;
      ex_operand_a_o    <= '0;
      ex_operand_b_o    <= '0;
      ex_operand_c_o    <= '0;
      ex_rf_we_o        <= 1'b0;
      ex_rf_waddr_o     <= '0;
      ex_lsu_en_o       <= 1'b0;
      ex_lsu_we_o       <= 1'b0;
      ex_lsu_type_o     <= LSU_BYTE;
      ex_lsu_sign_ext_o <= 1'b0;
      ex_branch_o       <= 1'b0;
      ex_illegal_o      <= 1'b0;
      ex_pc_o           <= '0;
    end else if (xfer) begin
      ex_valid_o <= 1'b1;
      // Operands are shared by ALU and LSU
      if (alu_en_i || lsu_en_i) begin
        ex_alu_operator_o <= alu_op_i;
        ex_operand_a_o    <= operand_a_i;
        ex_operand_b_o    <= operand_b_i;
        ex_operand_c_o    <= operand_c_i;
      end
      ex_rf_we_o <= rf_we_i;
      if (rf_we_i) begin
        ex_rf_waddr_o <= rd_i;
      end
      ex_lsu_en_o <= lsu_en_i;
      if (lsu_en_i) begin
        ex_lsu_we_o       <= lsu_we_i;
        ex_lsu_type_o     <= lsu_type_i;
        ex_lsu_sign_ext_o <= lsu_sign_ext_i;
      end
      ex_branch_o  <= (ctrl_xfer_i == XFER_COND);
      ex_illegal_o <= illegal_i;
      ex_pc_o      <= pc_i;
    end else if (ex_ready_i) begin
      // EX consumed its item and nothing new arrives
      ex_valid_o <= 1'b0;
    end
  end

  // Stalled EX sees a frozen register
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !ex_ready_i |=> $stable({ex_valid_o, ex_alu_operator_o, ex_operand_a_o,
      ex_operand_b_o, ex_operand_c_o, ex_rf_we_o, ex_rf_waddr_o, ex_lsu_en_o,
      ex_lsu_we_o, ex_lsu_type_o, ex_lsu_sign_ext_o, ex_branch_o,
      ex_illegal_o, ex_pc_o}));

  // Halt never lets an item into a ready EX
  a_no_valid_on_halt: assert property (@(posedge clk) disable iff (!rst_n)
    (halt_id_i && ex_ready_i) |=> !ex_valid_o);

endmodule

// File: rtl/id_stage.sv
// Register file is outside; its read data must return in the same cycle as rf_raddr_*_o
`timescale 1ns/10ps

module id_stage import id_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [XLEN-1:0]       instr_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic                  instr_valid_i,
  input  logic                  kill_id_i,
  input  logic                  halt_id_i,
  input  logic                  ex_ready_i,
  input  fw_sel_e               fw_a_sel_i,
  input  fw_sel_e               fw_b_sel_i,
  input  logic [XLEN-1:0]       rf_rdata_a_i,
  input  logic [XLEN-1:0]       rf_rdata_b_i,
  input  logic [XLEN-1:0]       rf_wdata_ex_i,
  input  logic [XLEN-1:0]       rf_wdata_wb_i,
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [1:0]            rf_re_o,
  output logic [XLEN-1:0]       jmp_target_o,
  output logic                  id_valid_o,
  output logic                  id_ready_o,
  output logic                  ex_valid_o,
  output alu_op_e               ex_alu_operator_o,
  output logic [XLEN-1:0]       ex_operand_a_o,
  output logic [XLEN-1:0]       ex_operand_b_o,
  output logic [XLEN-1:0]       ex_operand_c_o,
  output logic                  ex_rf_we_o,
  output logic [REG_ADDR_W-1:0] ex_rf_waddr_o,
  output logic                  ex_lsu_en_o,
  output logic                  ex_lsu_we_o,
  output lsu_type_e             ex_lsu_type_o,
  output logic                  ex_lsu_sign_ext_o,
  output logic                  ex_branch_o,
  output logic                  ex_illegal_o,
  output logic [XLEN-1:0]       ex_pc_o
);

  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [XLEN-1:0] operand_a, operand_b, operand_c;
  logic            alu_en, rf_we, lsu_en, lsu_we, lsu_sign_ext, illegal;
  alu_op_e         alu_op;
  op_a_sel_e       op_a_sel;
  op_b_sel_e       op_b_sel;
  imm_b_sel_e      imm_b_sel;
  op_c_sel_e       op_c_sel;
  lsu_type_e       lsu_type;
  ctrl_xfer_e      ctrl_xfer;

  // Register addresses straight from the instruction
  assign rf_raddr_a_o = instr_i[RS1_LSB +: REG_ADDR_W];
  assign rf_raddr_b_o = instr_i[RS2_LSB +: REG_ADDR_W];

  imm_gen imm_gen_inst (
    .instr_i (instr_i),
    .imm_i_o (imm_i),
    .imm_s_o (imm_s),
    .imm_b_o (imm_b),
    .imm_u_o (imm_u),
    .imm_j_o (imm_j)
  );

  instr_decoder instr_decoder_inst (
    .instr_i        (instr_i),
    .alu_en_o       (alu_en),
    .alu_op_o       (alu_op),
    .op_a_sel_o     (op_a_sel),
    .op_b_sel_o     (op_b_sel),
    .imm_b_sel_o    (imm_b_sel),
    .op_c_sel_o     (op_c_sel),
    .rf_re_o        (rf_re_o),
    .rf_we_o        (rf_we),
    .lsu_en_o       (lsu_en),
    .lsu_we_o       (lsu_we),
    .lsu_type_o     (lsu_type),
    .lsu_sign_ext_o (lsu_sign_ext),
    .ctrl_xfer_o    (ctrl_xfer),
    .illegal_o      (illegal)
  );

  operand_sel operand_sel_inst (
    .pc_i          (pc_i),
    .rf_rdata_a_i  (rf_rdata_a_i),
    .rf_rdata_b_i  (rf_rdata_b_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .fw_a_sel_i    (fw_a_sel_i),
    .fw_b_sel_i    (fw_b_sel_i),
    .op_a_sel_i    (op_a_sel),
    .op_b_sel_i    (op_b_sel),
    .imm_b_sel_i   (imm_b_sel),
    .op_c_sel_i    (op_c_sel),
    .ctrl_xfer_i   (ctrl_xfer),
    .imm_i_i       (imm_i),
    .imm_s_i       (imm_s),
    .imm_b_i       (imm_b),
    .imm_u_i       (imm_u),
    .imm_j_i       (imm_j),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .operand_c_o   (operand_c),
    .jmp_target_o  (jmp_target_o)
  );

  id_ex_reg id_ex_reg_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .instr_valid_i     (instr_valid_i),
    .kill_id_i         (kill_id_i),
    .halt_id_i         (halt_id_i),
    .ex_ready_i        (ex_ready_i),
    .alu_en_i          (alu_en),
    .alu_op_i          (alu_op),
    .operand_a_i       (operand_a),
    .operand_b_i       (operand_b),
    .operand_c_i       (operand_c),
    .rf_we_i           (rf_we),
    .rd_i              (instr_i[RD_LSB +: REG_ADDR_W]),
    .lsu_en_i          (lsu_en),
    .lsu_we_i          (lsu_we),
    .lsu_type_i        (lsu_type),
    .lsu_sign_ext_i    (lsu_sign_ext),
    .ctrl_xfer_i       (ctrl_xfer),
    .illegal_i         (illegal),
    .pc_i              (pc_i),
    .id_valid_o        (id_valid_o),
    .id_ready_o        (id_ready_o),
    .ex_valid_o        (ex_valid_o),
    .ex_alu_operator_o (ex_alu_operator_o),
    .ex_operand_a_o    (ex_operand_a_o),
    .ex_operand_b_o    (ex_operand_b_o),
    .ex_operand_c_o    (ex_operand_c_o),
    .ex_rf_we_o        (ex_rf_we_o),
    .ex_rf_waddr_o     (ex_rf_waddr_o),
    .ex_lsu_en_o       (ex_lsu_en_o),
    .ex_lsu_we_o       (ex_lsu_we_o),
    .ex_lsu_type_o     (ex_lsu_type_o),
    .ex_lsu_sign_ext_o (ex_lsu_sign_ext_o),
    .ex_branch_o       (ex_branch_o),
    .ex_illegal_o      (ex_illegal_o),
    .ex_pc_o           (ex_pc_o)
  );

  // An illegal instruction reaches EX flagged and with no write or memory access
  a_illegal_inert: assert property (@(posedge clk) disable iff (!rst_n)
    (id_valid_o && ex_ready_i && illegal) |=>
      (ex_illegal_o && !ex_rf_we_o && !ex_lsu_en_o));

endmodule

// File: tb/tb_id_stage.sv
// Needs tb/id_cases.txt relative to the run directory; stops at the first mismatch
`timescale 1ns/10ps

module tb_id_stage import id_pkg::*; ();

  localparam int NCOL = 28;

  logic                  clk;
  logic                  rst_n;
  logic [XLEN-1:0]       instr;
  logic [XLEN-1:0]       pc;
  logic                  instr_valid;
  logic                  kill_id;
  logic                  halt_id;
  logic                  ex_ready;
  fw_sel_e               fw_a_sel;
  fw_sel_e               fw_b_sel;
  logic [XLEN-1:0]       rf_rdata_a;
  logic [XLEN-1:0]       rf_rdata_b;
  logic [XLEN-1:0]       rf_wdata_ex;
  logic [XLEN-1:0]       rf_wdata_wb;
  logic [REG_ADDR_W-1:0] rf_raddr_a;
  logic [REG_ADDR_W-1:0] rf_raddr_b;
  logic [1:0]            rf_re;
  logic [XLEN-1:0]       jmp_target;
  logic                  id_valid;
  logic                  id_ready;
  logic                  ex_valid;
  alu_op_e               ex_alu_operator;
  logic [XLEN-1:0]       ex_operand_a;
  logic [XLEN-1:0]       ex_operand_b;
  logic [XLEN-1:0]       ex_operand_c;
  logic                  ex_rf_we;
  logic [REG_ADDR_W-1:0] ex_rf_waddr;
  logic                  ex_lsu_en;
  logic                  ex_lsu_we;
  lsu_type_e             ex_lsu_type;
  logic                  ex_lsu_sign_ext;
  logic                  ex_branch;
  logic                  ex_illegal;
  logic [XLEN-1:0]       ex_pc;

  // Case lines and the parsed columns of the current and previous case
  string       lines[$];
  logic [31:0] cur [0:NCOL-1];
  logic [31:0] prev [0:NCOL-1];
  logic        loaded;

  // Expected EX fields that load on every transfer
  logic            exp_branch;
  logic [XLEN-1:0] exp_pc;

  id_stage id_stage_inst (
    .clk (clk), .rst_n (rst_n), .instr_i (instr), .pc_i (pc),
    .instr_valid_i (instr_valid), .kill_id_i (kill_id), .halt_id_i (halt_id),
    .ex_ready_i (ex_ready), .fw_a_sel_i (fw_a_sel), .fw_b_sel_i (fw_b_sel),
    .rf_rdata_a_i (rf_rdata_a), .rf_rdata_b_i (rf_rdata_b),
    .rf_wdata_ex_i (rf_wdata_ex), .rf_wdata_wb_i (rf_wdata_wb),
    .rf_raddr_a_o (rf_raddr_a), .rf_raddr_b_o (rf_raddr_b), .rf_re_o (rf_re),
    .jmp_target_o (jmp_target), .id_valid_o (id_valid), .id_ready_o (id_ready),
    .ex_valid_o (ex_valid), .ex_alu_operator_o (ex_alu_operator),
    .ex_operand_a_o (ex_operand_a), .ex_operand_b_o (ex_operand_b),
    .ex_operand_c_o (ex_operand_c), .ex_rf_we_o (ex_rf_we),
    .ex_rf_waddr_o (ex_rf_waddr), .ex_lsu_en_o (ex_lsu_en),
    .ex_lsu_we_o (ex_lsu_we), .ex_lsu_type_o (ex_lsu_type),
    .ex_lsu_sign_ext_o (ex_lsu_sign_ext), .ex_branch_o (ex_branch),
    .ex_illegal_o (ex_illegal), .ex_pc_o (ex_pc)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp === act) else begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // Read enables per opcode with rs1 in bit 0 and rs2 in bit 1
  function automatic logic [1:0] reads_of(input logic [31:0] ins);
    case (ins[6:0])
      OPC_OP, OPC_BRANCH, OPC_STORE:  reads_of = 2'b11;
      OPC_OP_IMM, OPC_LOAD, OPC_JALR: reads_of = 2'b01;
      default:                        reads_of = 2'b00;
    endcase
  endfunction

  // Only LB, LH and LW sign-extend
  function automatic logic load_is_signed(input logic [31:0] ins);
    load_is_signed = (ins[6:0] == OPC_LOAD) && (ins[14:12] == 3'b000 ||
                     ins[14:12] == 3'b001 || ins[14:12] == 3'b010);
  endfunction

  // Outputs that follow the current inputs
  task automatic check_comb();
    check_value("id_valid_o", cur[12], 32'(id_valid));
    check_value("id_ready_o", cur[13], 32'(id_ready));
    if (cur[14][0]) begin
      check_value("jmp_target_o", cur[15], jmp_target);
    end
    // Register addresses are the rs1 and rs2 fields of the instruction
    check_value("rf_raddr_a_o", 32'(cur[0][19:15]), 32'(rf_raddr_a));
    check_value("rf_raddr_b_o", 32'(cur[0][24:20]), 32'(rf_raddr_b));
    check_value("rf_re_o", 32'(reads_of(cur[0])), 32'(rf_re));
  endtask

  // Register contents one edge after a case was applied
  task automatic check_ex();
    // Transfer on the edge just passed when ID was valid and EX ready
    if (prev[12][0] && prev[11][0]) begin
      exp_branch = (prev[0][6:0] == OPC_BRANCH);
      exp_pc     = prev[1];
    end
    check_value("ex_valid_o", prev[16], 32'(ex_valid));
    // Operator and operands only when ALU or LSU captured them
    if (prev[17][0]) begin
      check_value("ex_alu_operator_o", prev[18], 32'(ex_alu_operator));
      check_value("ex_operand_a_o", prev[19], ex_operand_a);
      check_value("ex_operand_b_o", prev[20], ex_operand_b);
      check_value("ex_operand_c_o", prev[21], ex_operand_c);
    end
    check_value("ex_rf_we_o", prev[22], 32'(ex_rf_we));
    if (prev[22][0]) begin
      check_value("ex_rf_waddr_o", prev[23], 32'(ex_rf_waddr));
    end
    check_value("ex_lsu_en_o", prev[24], 32'(ex_lsu_en));
    if (prev[24][0]) begin
      check_value("ex_lsu_we_o", prev[25], 32'(ex_lsu_we));
      check_value("ex_lsu_type_o", prev[26], 32'(ex_lsu_type));
      check_value("ex_lsu_sign_ext_o", 32'(load_is_signed(prev[0])), 32'(ex_lsu_sign_ext));
    end
    check_value("ex_illegal_o", prev[27], 32'(ex_illegal));
    check_value("ex_branch_o", 32'(exp_branch), 32'(ex_branch));
    check_value("ex_pc_o", exp_pc, ex_pc);
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic load_cases();
    int    fd;
    string line;
    fd = $fopen("tb/id_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file tb/id_cases.txt");
      $display("Finished with errors");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Skip comments and blank lines
      if (line.len() > 8 && line.getc(0) != "#") begin
        lines.push_back(line);
      end
    end
    $fclose(fd);
  endtask

  // Parse one line and drive its stimulus on this edge
  task automatic apply_case(input string line);
    int n;
    n = $sscanf(line,
      "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
      cur[0], cur[1], cur[2], cur[3], cur[4], cur[5], cur[6], cur[7],
      cur[8], cur[9], cur[10], cur[11], cur[12], cur[13], cur[14],
      cur[15], cur[16], cur[17], cur[18], cur[19], cur[20], cur[21],
      cur[22], cur[23], cur[24], cur[25], cur[26], cur[27]);
    if (n != NCOL) begin
      $display("Malformed case line with %0d columns: %s", n, line);
      $display("Finished with errors");
      $fatal(1);
    end
    instr       <= cur[0];
    pc          <= cur[1];
    rf_rdata_a  <= cur[2];
    rf_rdata_b  <= cur[3];
    rf_wdata_ex <= cur[4];
    rf_wdata_wb <= cur[5];
    fw_a_sel    <= fw_sel_e'(cur[6][1:0]);
    fw_b_sel    <= fw_sel_e'(cur[7][1:0]);
    instr_valid <= cur[8][0];
    kill_id     <= cur[9][0];
    halt_id     <= cur[10][0];
    ex_ready    <= cur[11][0];
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    instr = '0;
    pc = '0;
    instr_valid = 1'b0;
    kill_id = 1'b0;
    halt_id = 1'b0;
    ex_ready = 1'b0;
    fw_a_sel = SEL_REGFILE;
    fw_b_sel = SEL_REGFILE;
    rf_rdata_a = '0;
    rf_rdata_b = '0;
    rf_wdata_ex = '0;
    rf_wdata_wb = '0;
    exp_branch = 1'b0;
    exp_pc = '0;
    loaded = 1'b0;
    load_cases();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    // One case per cycle; EX side of a case is checked in the next cycle
    for (int i = 0; i < lines.size(); i++) begin
      @(posedge clk);
      prev = cur;
      apply_case(lines[i]);
      @(negedge clk);
      check_comb();
      if (i > 0) begin
        check_ex();
      end
    end
    @(posedge clk);
    prev = cur;
    instr_valid <= 1'b0;
    ex_ready    <= 1'b0;
    @(negedge clk);
    check_ex();
    $display("Finished with no errors");
    $finish;
  end

  // Watchdog sized from the case count
  initial begin
    wait (loaded);
    #((lines.size() + 20) * 40);
    $display("Finished with errors");
    $fatal(1, "Run timed out before all cases were applied");
  end

endmodule

// File: tb/id_cases.txt
# instr pc rdata_a rdata_b wdata_ex wdata_wb fw_a fw_b valid kill halt ex_ready (all hex)
# id_valid id_ready jmp_chk jmp_target ex_valid ops_chk op a b c rf_we rd lsu_en lsu_we lsu_type illegal
# ADDI x5, x1, -8
FF808293 00001000 00000100 00000200 00000300 00000400 0 0 1 0 0 1 1 1 0 00000000 1 1 00 00000100 FFFFFFF8 00000000 1 05 0 0 0 0
# SUB x6, x1, x2
40208333 00001000 00000100 00000200 00000300 00000400 0 0 1 0 0 1 1 1 0 00000000 1 1 01 00000100 00000200 00000000 1 06 0 0 0 0
# LUI x7, 0x12345
123453B7 00001000 00000100 00000200 00000300 00000400 0 0 1 0 0 1 1 1 0 00000000 1 1 00 00000000 12345000 00000000 1 07 0 0 0 0
# AUIPC x8, 0x10
00010417 00001000 00000100 00000200 00000300 00000400 0 0 1 0 0 1 1 1 0 00000000 1 1 00 00001000 00010000 00000000 1 08 0 0 0 0
# ADD x9, x1, x2 from register file, then EX/WB, then WB/EX
002084B3 00001000 00000100 00000200 00000300 00000400 0 0 1 0 0 1 1 1 0 00000000 1 1 00 00000100 00000200 00000000 1 09 0 0 0 0
002084B3 00001000 00000100 00000200 00000300 00000400 1 2 1 0 0 1 1 1 0 00000000 1 1 00 00000300 00000400 00000000 1 09 0 0 0 0
002084B3 00001000 00000100 00000200 00000300 00000400 2 1 1 0 0 1 1 1 0 00000000 1 1 00 00000400 00000300 00000000 1 09 0 0 0 0
# JAL x1, +0x20
020000EF 00001000 00000100 00000200 00000300 00000400 0 0 1 0 0 1 1 1 1 00001020 1 1 00 00001000 00000004 00000000 1 01 0 0 0 0
# JALR x1, 5(x3) with rs1 from EX
005180E7 00001000 00000100 00000200 00000300 00000400 1 0 1 0 0 1 1 1 1 00000304 1 1 00 00001000 00000004 00000000 1 01 0 0 0 0
# BEQ x1, x2, +16
00208863 00001000 00000100 00000200 00000300 00000400 0 0 1 0 0 1 1 1 1 00001010 1 1 0A 00000100 00000200 00001010 0 00 0 0 0 0
# LW x10, 8(x1)
0080A503 00001000 00000100 00000200 00000300 00000400 0 0 1 0 0 1 1 1 0 00000000 1 1 00 00000100 00000008 00000000 1 0A 1 0 2 0
# SW x2, 12(x1)
0020A623 00001000 00000100 00000200 00000300 00000400 0 0 1 0 0 1 1 1 0 00000000 1 1 00 00000100 0000000C 00000200 0 00 1 1 2 0
# ECALL, SYSTEM opcode is illegal
00000073 00001000 00000100 00000200 00000300 00000400 0 0 1 0 0 1 1 1 0 00000000 1 0 00 00000000 00000000 00000000 0 00 0 0 0 1
# ADDI x0, x1, 1 drops the write
00108013 00001000 00000100 00000200 00000300 00000400 0 0 1 0 0 1 1 1 0 00000000 1 1 00 00000100 00000001 00000000 0 00 0 0 0 0
# Halt blocks issue, EX drains
FF808293 00001000 00000100 00000200 00000300 00000400 0 0 1 0 1 1 0 0 0 00000000 0 0 00 00000000 00000000 00000000 0 00 0 0 0 0
# Normal transfer to fill EX
FF808293 00001000 00000100 00000200 00000300 00000400 0 0 1 0 0 1 1 1 0 00000000 1 1 00 00000100 FFFFFFF8 00000000 1 05 0 0 0 0
# EX stalled, register holds
40208333 00001000 00000100 00000200 00000300 00000400 0 0 1 0 0 0 1 0 0 00000000 1 1 00 00000100 FFFFFFF8 00000000 1 05 0 0 0 0
# No valid with EX ready, valid clears
FF808293 00001000 00000100 00000200 00000300 00000400 0 0 0 0 0 1 0 1 0 00000000 0 0 00 00000000 00000000 00000000 1 05 0 0 0 0
# Kill forces ready even when EX stalls
FF808293 00001000 00000100 00000200 00000300 00000400 0 0 1 1 0 0 0 1 0 00000000 0 0 00 00000000 00000000 00000000 1 05 0 0 0 0
# Idle
FF808293 00001000 00000100 00000200 00000300 00000400 0 0 0 0 0 1 0 1 0 00000000 0 0 00 00000000 00000000 00000000 1 05 0 0 0 0

// File: flist.f
rtl/id_pkg.sv
rtl/imm_gen.sv
rtl/instr_decoder.sv
rtl/operand_sel.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
tb/tb_id_stage.sv
